/* hw/board_defs.svh */
`ifndef BOARD_DEFS_SVH
`define BOARD_DEFS_SVH

// number of scanned display positions
`define BOARD_N_DIGIT   4

// clock cycles per count tick, 10 Hz at 10 MHz
`define BOARD_TICK_DIV  1000000

// clock cycles per display scan step
`define BOARD_SCAN_DIV  1000

`endif

/* hw/board_pkg.sv */
`include "board_defs.svh"

package board_pkg;

    // width of the scan index, at least one bit
    localparam int scan_idx_w = (`BOARD_N_DIGIT > 1) ? $clog2(`BOARD_N_DIGIT) : 1;

    // one decimal digit, 0 to 9
    typedef logic [3:0] bcd_t;

    // segments a..h, a in bit 7, decimal point in bit 0
    typedef logic [7:0] seg_t;

    // one-hot position select, active high
    typedef logic [`BOARD_N_DIGIT - 1:0] digit_sel_t;

    typedef logic [scan_idx_w - 1:0] scan_idx_t;

    // bit 0 run/stop, bit 1 clear
    typedef logic [1:0] key_t;

endpackage

/* hw/tick_gen.sv */
`timescale 1ns/1ps
`include "board_defs.svh"

module tick_gen
#(
    parameter tick_div = `BOARD_TICK_DIV
)
(
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    localparam w_cnt = (tick_div > 1) ? $clog2(tick_div) : 1;

    logic [w_cnt - 1:0] cnt;

    // terminal count marks the last cycle of each period
    assign tick = (cnt == w_cnt'(tick_div - 1));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            cnt <= '0;
        else if (tick)
            cnt <= '0;
        else
            cnt <= cnt + 1'b1;
    end

endmodule

/* hw/key_control.sv */
`timescale 1ns/1ps

module key_control
(
    input  logic            clk,
    input  logic            rst_n,
    input  board_pkg::key_t key,
    input  logic            tick,
    input  logic            wrap,
    output logic            count_en,
    output logic            clear,
    output logic [1:0]      led
);

    import board_pkg::*;

    key_t key_s1;
    key_t key_s2;
    logic run_key_q;
    logic run_rise;
    logic run;
    logic overflow;

    //------------------------------------------------------------------------
    // key synchronizer and run key edge

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            key_s1    <= '0;
            key_s2    <= '0;
            run_key_q <= 1'b0;
        end
        else
        begin
            key_s1    <= key;
            key_s2    <= key_s1;
            run_key_q <= key_s2[0];
        end
    end

    assign run_rise = key_s2[0] & ~run_key_q;
    assign clear    = key_s2[1];

    //------------------------------------------------------------------------
    // run and overflow flags

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            run <= 1'b0;
        else if (run_rise)
            run <= ~run;
    end

    // sticky until the clear key
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            overflow <= 1'b0;
        else if (clear)
            overflow <= 1'b0;
        else if (wrap)
            overflow <= 1'b1;
    end

    assign count_en = tick & run & ~clear;
    assign led      = {overflow, run};

    a_clear_blocks_count: assert property (
        @(posedge clk) disable iff (!rst_n)
        clear |-> !count_en
    );

endmodule

/* hw/digit_counter.sv */
`timescale 1ns/1ps

module digit_counter
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            clear,
    input  logic            carry_in,
    output logic            carry_out,
    output board_pkg::bcd_t value
);

    import board_pkg::*;

    localparam bcd_t digit_max = 4'd9;

    logic at_max;

    assign at_max = (value == digit_max);

    // carry ripples straight through while this digit sits at 9
    assign carry_out = carry_in & at_max;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            value <= '0;
        else if (clear)
            value <= '0;
        else if (carry_in)
        begin
            if (at_max)
                value <= '0;
            else
                value <= value + 1'b1;
        end
    end

    a_value_bcd: assert property (
        @(posedge clk) disable iff (!rst_n)
        value <= digit_max
    );

endmodule

/* hw/seg_scanner.sv */
`timescale 1ns/1ps
`include "board_defs.svh"

module seg_scanner
#(
    parameter scan_div = `BOARD_SCAN_DIV
)
(
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  board_pkg::bcd_t [`BOARD_N_DIGIT - 1:0] digits,
    output board_pkg::seg_t                       abcdefgh,
    output board_pkg::digit_sel_t                 digit
);

    import board_pkg::*;

    localparam w_div = (scan_div > 1) ? $clog2(scan_div) : 1;
    localparam scan_idx_t last_idx = scan_idx_t'(`BOARD_N_DIGIT - 1);
    localparam seg_t seg_zero = 8'hFC;

    logic [w_div - 1:0] div_cnt;
    logic               step;
    logic               step_q;
    scan_idx_t          idx;
    bcd_t               cur_bcd;
    seg_t               cur_seg;

    //------------------------------------------------------------------------
    // scan divider and position index

    assign step = (div_cnt == w_div'(scan_div - 1));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            div_cnt <= '0;
            idx     <= '0;
            step_q  <= 1'b0;
        end
        else
        begin
            step_q <= step;

            if (step)
            begin
                div_cnt <= '0;
                idx     <= (idx == last_idx) ? '0 : idx + 1'b1;
            end
            else
                div_cnt <= div_cnt + 1'b1;
        end
    end

    //------------------------------------------------------------------------
    // bcd to segments, decimal point off

    assign cur_bcd = digits[idx];

    always_comb
    begin
        case (cur_bcd)
            4'd0:    cur_seg = seg_zero;
            4'd1:    cur_seg = 8'h60;
            4'd2:    cur_seg = 8'hDA;
            4'd3:    cur_seg = 8'hF2;
            4'd4:    cur_seg = 8'h66;
            4'd5:    cur_seg = 8'hB6;
            4'd6:    cur_seg = 8'hBE;
            4'd7:    cur_seg = 8'hE0;
            4'd8:    cur_seg = 8'hFE;
            4'd9:    cur_seg = 8'hF6;
            default: cur_seg = 8'h00;
        endcase
    end

    // outputs move one cycle after the index
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            abcdefgh <= seg_zero;
            digit    <= digit_sel_t'(1);
        end
        else if (step_q)
        begin
            abcdefgh <= cur_seg;
            digit    <= digit_sel_t'(1) << idx;
        end
    end

    a_digit_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot(digit)
    );

endmodule

/* hw/lab_top.sv */
`timescale 1ns/1ps
`include "board_defs.svh"

module lab_top
#(
    parameter scan_div = `BOARD_SCAN_DIV
)
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  tick,
    input  board_pkg::key_t       key,
    output logic [1:0]            led,
    output board_pkg::seg_t       abcdefgh,
    output board_pkg::digit_sel_t digit
);

    import board_pkg::*;

    localparam n_digit = `BOARD_N_DIGIT;

    // carry[0] is the gated tick, the top bit is the wrap past all nines
    logic [n_digit:0]     carry;
    logic                 clear;
    bcd_t [n_digit - 1:0] digits;

    //------------------------------------------------------------------------

    key_control i_key_control
    (
        .clk      ( clk            ),
        .rst_n    ( rst_n          ),
        .key      ( key            ),
        .tick     ( tick           ),
        .wrap     ( carry[n_digit] ),
        .count_en ( carry[0]       ),
        .clear    ( clear          ),
        .led      ( led            )
    );

    //------------------------------------------------------------------------
    // digit 0 is the least significant

    generate
        genvar i;

        for (i = 0; i < n_digit; i++)
        begin : gen_digit
            digit_counter i_digit
            (
                .clk       ( clk          ),
                .rst_n     ( rst_n        ),
                .clear     ( clear        ),
                .carry_in  ( carry[i]     ),
                .carry_out ( carry[i + 1] ),
                .value     ( digits[i]    )
            );
        end
    endgenerate

    seg_scanner #(.scan_div (scan_div)) i_seg_scanner
    (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .digits   ( digits   ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

endmodule

/* hw/board_top.sv */
`timescale 1ns/1ps
`include "board_defs.svh"

module board_top
#(
    parameter tick_div = `BOARD_TICK_DIV,
              scan_div = `BOARD_SCAN_DIV
)
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  board_pkg::key_t       key,
    output logic [1:0]            led,
    output board_pkg::seg_t       abcdefgh,
    output board_pkg::digit_sel_t digit
);

    // one-cycle count strobe on clk
    logic tick;

    tick_gen #(.tick_div (tick_div)) i_tick_gen
    (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .tick  ( tick  )
    );

    lab_top #(.scan_div (scan_div)) i_lab_top
    (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .tick     ( tick     ),
        .key      ( key      ),
        .led      ( led      ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

endmodule

/* testbench/tb_board_top.sv */
`timescale 1ns/1ps
`include "board_defs.svh"

module tb_board_top;

    import board_pkg::*;

    localparam int tick_div  = 8;
    localparam int scan_div  = 4;
    localparam int n_digit   = `BOARD_N_DIGIT;
    localparam int n_rows    = 10;
    localparam int read_len  = n_digit * scan_div + 2;
    // stop press, settle, one full scan, sampling, restart press
    localparam int read_cost = 1 + 3 + read_len + read_len + 2;

    localparam seg_t seg_table [10] = '{8'hFC, 8'h60, 8'hDA, 8'hF2, 8'h66,
                                        8'hB6, 8'hBE, 8'hE0, 8'hFE, 8'hF6};

    // key 0 press, key 1 level, hold cycles with 0 for a random length
    localparam bit table_press [n_rows] = '{0, 1, 1, 1, 0, 0, 1, 1, 1, 1};
    localparam bit table_clear [n_rows] = '{0, 0, 0, 0, 0, 1, 0, 0, 0, 0};
    localparam int table_hold  [n_rows] = '{5, 40, 20, 8000, 73000, 6, 0, 0, 0, 0};

    logic       clk;
    logic       rst_n;
    key_t       key;
    logic [1:0] led;
    seg_t       abcdefgh;
    digit_sel_t digit;

    int unsigned rng;
    int          hold_len [n_rows];
    int          timeout_limit;
    int          timeout_count = 0;

    // reference model state
    int   edge_idx;
    int   model_count;
    logic model_run;
    logic model_ovf;
    key_t key_hist [4];

    board_top #(.tick_div (tick_div), .scan_div (scan_div)) UUT
    (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .key      ( key      ),
        .led      ( led      ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        timeout_count <= timeout_count + 1;
        if (timeout_limit > 0 && timeout_count > timeout_limit)
            stop_on_failure("timeout: the test did not finish within the cycle limit");
    end

    //------------------------------------------------------------------------
    // failure reporting and compares

    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_seg(input seg_t got, input seg_t exp, input string what);
        if (got !== exp)
            stop_on_failure($sformatf("ERR %0t: %s segments %h expected %h",
                                      $time, what, got, exp));
    endtask

    task automatic check_led(input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp)
            stop_on_failure($sformatf("ERR %0t: led %b expected %b", $time, got, exp));
    endtask

    function automatic int unsigned xorshift(input int unsigned x);
        int unsigned y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    //------------------------------------------------------------------------
    // one clock cycle, model update at the edge, then drive keys

    task automatic run_cycle(input key_t k);
        logic rise;
        logic clr;
        logic tick;
        @(posedge clk);
        edge_idx++;
        // keys reach the flags three edges after they are driven
        rise = key_hist[2][0] & ~key_hist[3][0];
        clr  = key_hist[2][1];
        tick = (edge_idx % tick_div == 0);
        if (clr)
        begin
            model_count = 0;
            model_ovf   = 1'b0;
        end
        else if (tick && model_run)
        begin
            if (model_count == 9999)
            begin
                model_count = 0;
                model_ovf   = 1'b1;
            end
            else
                model_count++;
        end
        if (rise)
            model_run = ~model_run;
        #10;
        check_led(led, {model_ovf, model_run});
        key = k;
        key_hist[3] = key_hist[2];
        key_hist[2] = key_hist[1];
        key_hist[1] = key_hist[0];
        key_hist[0] = k;
    endtask

    // freeze the count, watch a full scan, compare every position
    task automatic read_display(input int row);
        logic was_running;
        seg_t seen [n_digit];
        bit   got  [n_digit];
        int   pos;
        int   prev;
        int   val;
        was_running = model_run;
        prev = -1;
        for (int p = 0; p < n_digit; p++)
            got[p] = 1'b0;
        if (was_running)
        begin
            run_cycle(2'b01);
            repeat (3) run_cycle(2'b00);
        end
        repeat (read_len) run_cycle(2'b00);
        repeat (read_len)
        begin
            run_cycle(2'b00);
            if (!$onehot(digit))
                stop_on_failure($sformatf("digit select %b is not one-hot", digit));
            pos = 0;
            for (int p = 0; p < n_digit; p++)
                if (digit[p])
                    pos = p;
            if (prev >= 0 && pos != prev && pos != (prev + 1) % n_digit)
                stop_on_failure($sformatf("scan jumped from position %0d to %0d", prev, pos));
            prev      = pos;
            seen[pos] = abcdefgh;
            got[pos]  = 1'b1;
        end
        val = model_count;
        for (int p = 0; p < n_digit; p++)
        begin
            if (!got[p])
                stop_on_failure($sformatf("position %0d was never selected", p));
            check_seg(seen[p], seg_table[val % 10],
                      $sformatf("row %0d position %0d", row, p));
            val = val / 10;
        end
        if (was_running)
        begin
            run_cycle(2'b01);
            run_cycle(2'b00);
        end
    endtask

    //------------------------------------------------------------------------

    initial
    begin
        rst_n       = 1'b0;
        key         = '0;
        edge_idx    = 0;
        model_count = 0;
        model_run   = 1'b0;
        model_ovf   = 1'b0;
        for (int i = 0; i < 4; i++)
            key_hist[i] = '0;

        rng           = 32'd8150;
        timeout_limit = 20;
        for (int r = 0; r < n_rows; r++)
        begin
            if (table_hold[r] == 0)
            begin
                rng         = xorshift(rng);
                hold_len[r] = int'(rng % 200) + 10;
            end
            else
                hold_len[r] = table_hold[r];
            timeout_limit = timeout_limit + hold_len[r] + read_cost;
        end
        timeout_limit = 2 * timeout_limit;

        repeat (10) @(posedge clk);
        #10 rst_n = 1'b1;

        for (int r = 0; r < n_rows; r++)
        begin
            run_cycle({table_clear[r], table_press[r]});
            for (int c = 1; c < hold_len[r]; c++)
                run_cycle({table_clear[r], 1'b0});
            read_display(r);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* flist.f */
+incdir+hw
hw/board_pkg.sv
hw/tick_gen.sv
hw/key_control.sv
hw/digit_counter.sv
hw/seg_scanner.sv
hw/lab_top.sv
hw/board_top.sv
testbench/tb_board_top.sv

/* Makefile */
# Verilator simulation of the board counter testbench

VERILATOR ?= verilator
TOP       ?= tb_board_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
